/* build.f */
c16_map_pkg.sv
c16_load_pkg.sv
prg_loader.sv
c16_bus_decode.sv
tape_player.sv
c16_sys_ctrl.sv
c16_sys_ctrl_sva.sv
tb_c16_sys_ctrl.sv

/* Makefile */
# Verilator flow for the C16 system-control testbench

VERILATOR ?= verilator
TB_TOP    ?= tb_c16_sys_ctrl
RTL_TOP   ?= c16_sys_ctrl
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= sim_$(TB_TOP)
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* tb_c16_sys_ctrl.sv */
module tb_c16_sys_ctrl;

	localparam int TAPE_ADDR_W = 8;
	localparam int CLK_PERIOD  = 4;
	localparam int PRG_LEN     = 20;
	localparam int TAPE_LEN    = 30;

	// Rough cycle budget of each test
	localparam int LEN_PRG   = (PRG_LEN + 2) * 3 + 40;
	localparam int LEN_RAM   = 2 * 6;
	localparam int LEN_BANK  = 16 * 20 + 16 * 20;
	localparam int LEN_CART  = 80;
	localparam int LEN_TAPE  = TAPE_LEN * 12 + (TAPE_LEN + 2) * 20 + 80;
	localparam int WATCHDOG_T =
		2 * (LEN_PRG + LEN_RAM + LEN_BANK + LEN_CART + LEN_TAPE) * CLK_PERIOD;

	logic        clk_sys = 1'b0;
	logic        reset = 1'b1;
	logic        ioctl_download_i = 1'b0;
	logic [7:0]  ioctl_index_i = 8'd0;
	logic        ioctl_wr_i = 1'b0;
	logic [24:0] ioctl_addr_i = '0;
	logic [7:0]  ioctl_dout_i = 8'd0;
	logic [15:0] cpu_addr_i = 16'd0;
	logic [7:0]  cpu_dout_i = 8'd0;
	logic        cpu_rnw_i = 1'b1;
	logic        cs_ram_n_i = 1'b1;
	logic        cs0_n_i = 1'b1;
	logic        cs1_n_i = 1'b1;
	logic        cs_io_n_i = 1'b1;
	logic        model_plus4_i = 1'b1;
	logic        kernal_std_i = 1'b0;
	logic [7:0]  mem_dout_i = 8'd0;
	logic        mem_ready_i = 1'b1;
	logic        fifo_full_i = 1'b0;
	logic        fifo_empty_i = 1'b0;
	logic        tape_play_btn_i = 1'b0;
	logic        tape_unload_i = 1'b0;

	logic                   ioctl_wait_o;
	c16_map_pkg::rom_src_e  rom_sel_o;
	logic                   tape_sense_o;
	logic [15:0]            ram_addr_o;
	logic [7:0]             ram_data_o;
	logic                   ram_wr_o;
	logic                   ram_we_o;
	logic [15:0]            ram_cpu_addr_o;
	logic [7:0]             ram_cpu_data_o;
	logic [TAPE_ADDR_W-1:0] mem_addr_o;
	logic [7:0]             mem_din_o;
	logic                   mem_we_o;
	logic                   mem_rd_o;
	logic                   fifo_wr_o;
	logic [7:0]             fifo_data_o;
	logic                   tape_play_o;

	integer      seed = 32'h4858;
	logic        full_rand_en = 1'b0;
	logic [7:0]  ram [65536];
	logic [7:0]  tape_mem [256];
	logic [2:0]  mem_delay;
	logic [TAPE_ADDR_W-1:0] rd_addr;
	logic [15:0] prg_load_addr;
	logic [15:0] prg_end_addr;
	logic [7:0]  prg_bytes [PRG_LEN];
	logic [7:0]  tape_bytes [TAPE_LEN];
	logic [7:0]  exp_q [$];

	c16_sys_ctrl #(
		.TAPE_ADDR_W (TAPE_ADDR_W)
	) c16_sys_ctrl_i (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	//////////////////////////////////////////////////////////////
	// Reporting
	//////////////////////////////////////////////////////////////

	task automatic stop_with_failure();
		$display("test failed");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic report_failure(input string why);
		$display("%s", why);
		stop_with_failure();
	endtask

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
		assert (exp === act) else begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			stop_with_failure();
		end
	endtask

	initial begin
		#(WATCHDOG_T);
		report_failure("watchdog expired before all tests finished");
	end

	//////////////////////////////////////////////////////////////
	// Models
	//////////////////////////////////////////////////////////////

	function automatic logic [7:0] fill_byte(input int addr);
		return 8'(addr) ^ 8'hA5;
	endfunction

	always @(posedge clk_sys) begin
		if (ram_wr_o)
			ram[ram_addr_o] <= ram_data_o;
	end

	// Tape memory with ready dropping on each access
	always @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < 256; i++)
				tape_mem[i] <= fill_byte(i);
			mem_ready_i <= 1'b1;
			mem_delay   <= 3'd0;
		end else if (mem_we_o) begin
			tape_mem[mem_addr_o] <= mem_din_o;
			mem_ready_i <= 1'b0;
			mem_delay   <= 3'(1 + ($random(seed) & 3));
		end else if (mem_rd_o) begin
			rd_addr     <= mem_addr_o;
			mem_ready_i <= 1'b0;
			mem_delay   <= 3'(1 + ($random(seed) & 3));
		end else if (mem_delay != 3'd0) begin
			mem_delay <= mem_delay - 3'd1;
			if (mem_delay == 3'd1) begin
				mem_ready_i <= 1'b1;
				mem_dout_i  <= tape_mem[rd_addr];
			end
		end
	end

	always @(posedge clk_sys) begin
		if (full_rand_en)
			fifo_full_i <= (($random(seed) & 3) == 0);
		else
			fifo_full_i <= 1'b0;
	end

	// Compare every FIFO push against the expected tape stream
	always @(posedge clk_sys) begin
		logic [7:0] exp_byte;
		if (!reset && fifo_wr_o) begin
			if (exp_q.size() == 0)
				report_failure("FIFO write seen with no tape byte left to expect");
			exp_byte = exp_q.pop_front();
			check_val("tape_fifo", 16'(exp_byte), 16'(fifo_data_o));
		end
	end

	//////////////////////////////////////////////////////////////
	// Reference
	//////////////////////////////////////////////////////////////

	function automatic c16_map_pkg::rom_src_e rom_ref(input logic sel0_n, input logic sel1_n,
			input logic [15:0] addr, input logic [3:0] cfg, input logic lo_ok,
			input logic hi_ok, input logic kstd);
		logic [1:0] lo;
		logic [1:0] hi;
		lo = cfg[1:0];
		hi = cfg[3:2];
		if (!sel0_n) begin
			if (lo == 2'd0)
				return c16_map_pkg::ROM_BASIC;
			if (lo == 2'd1)
				return lo_ok ? c16_map_pkg::ROM_CART_LO : c16_map_pkg::ROM_NONE;
			if (lo == 2'd2)
				return c16_map_pkg::ROM_FUNC_LO;
			return c16_map_pkg::ROM_NONE;
		end
		if (!sel1_n) begin
			if (addr[15:8] == 8'hFC || hi == 2'd0)
				return kstd ? c16_map_pkg::ROM_KERNAL_STD : c16_map_pkg::ROM_KERNAL;
			if (hi == 2'd1)
				return hi_ok ? c16_map_pkg::ROM_CART_HI : c16_map_pkg::ROM_NONE;
			if (hi == 2'd2)
				return c16_map_pkg::ROM_FUNC_HI;
		end
		return c16_map_pkg::ROM_NONE;
	endfunction

	//////////////////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////////////////

	task automatic do_reset(input logic plus4);
		@(posedge clk_sys);
		model_plus4_i <= plus4;
		reset <= 1'b1;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	// Config value comes from the low address nibble
	task automatic write_cfg(input logic [15:0] addr);
		@(posedge clk_sys);
		cpu_addr_i <= addr;
		cpu_rnw_i  <= 1'b0;
		cs_io_n_i  <= 1'b0;
		@(posedge clk_sys);
		cs_io_n_i <= 1'b1;
		@(posedge clk_sys);
		cpu_rnw_i <= 1'b1;
	endtask

	// CPU access to main RAM, the write pulse follows the select release
	task automatic cpu_ram_access(input string name, input logic [15:0] addr,
			input logic [7:0] data, input logic rnw);
		@(posedge clk_sys);
		cpu_addr_i <= addr;
		cpu_dout_i <= data;
		cpu_rnw_i  <= rnw;
		cs_ram_n_i <= 1'b0;
		@(posedge clk_sys);
		cs_ram_n_i <= 1'b1;
		@(posedge clk_sys);
		cpu_rnw_i <= 1'b1;
		@(negedge clk_sys);
		check_val(name, 16'(!rnw), 16'(ram_we_o));
		check_val({name, "_addr"}, addr, ram_cpu_addr_o);
		check_val({name, "_data"}, 16'(data), 16'(ram_cpu_data_o));
		@(negedge clk_sys);
		check_val({name, "_end"}, 16'd0, 16'(ram_we_o));
	endtask

	task automatic check_rom(input string name, input logic sel0_n, input logic sel1_n,
			input logic [15:0] addr, input logic [3:0] cfg, input logic lo_ok,
			input logic hi_ok);
		@(posedge clk_sys);
		cs0_n_i    <= sel0_n;
		cs1_n_i    <= sel1_n;
		cpu_addr_i <= addr;
		@(negedge clk_sys);
		check_val(name, 16'(rom_ref(sel0_n, sel1_n, addr, cfg, lo_ok, hi_ok, kernal_std_i)),
			16'(rom_sel_o));
		@(posedge clk_sys);
		cs0_n_i <= 1'b1;
		cs1_n_i <= 1'b1;
	endtask

	task automatic load_prg();
		@(posedge clk_sys);
		ioctl_index_i    <= 8'(c16_load_pkg::DL_PRG);
		ioctl_download_i <= 1'b1;
		for (int i = 0; i < PRG_LEN + 2; i++) begin
			@(posedge clk_sys);
			ioctl_addr_i <= 25'(i);
			if (i == 0)
				ioctl_dout_i <= prg_load_addr[7:0];
			else if (i == 1)
				ioctl_dout_i <= prg_load_addr[15:8];
			else
				ioctl_dout_i <= prg_bytes[i-2];
			ioctl_wr_i <= 1'b1;
			@(posedge clk_sys);
			ioctl_wr_i <= 1'b0;
		end
		@(posedge clk_sys);
		ioctl_download_i <= 1'b0;
		// Eight patch writes at one every second cycle
		repeat (24) @(posedge clk_sys);
	endtask

	task automatic load_cart(input logic [24:0] addr);
		@(posedge clk_sys);
		ioctl_index_i    <= 8'(c16_load_pkg::DL_CART);
		ioctl_download_i <= 1'b1;
		ioctl_addr_i     <= addr;
		ioctl_dout_i     <= 8'h55;
		ioctl_wr_i       <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr_i <= 1'b0;
		@(posedge clk_sys);
		ioctl_download_i <= 1'b0;
	endtask

	task automatic load_tape();
		@(posedge clk_sys);
		ioctl_index_i    <= 8'(c16_load_pkg::DL_TAPE);
		ioctl_download_i <= 1'b1;
		for (int i = 0; i < TAPE_LEN; i++) begin
			@(posedge clk_sys);
			ioctl_addr_i <= 25'(i);
			ioctl_dout_i <= tape_bytes[i];
			ioctl_wr_i   <= 1'b1;
			@(posedge clk_sys);
			ioctl_wr_i <= 1'b0;
			@(negedge clk_sys);
			while (ioctl_wait_o)
				@(negedge clk_sys);
		end
		@(posedge clk_sys);
		ioctl_download_i <= 1'b0;
	endtask

	//////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////

	initial begin
		prg_load_addr = 16'(32'h1000 + ($random(seed) & 32'h7FFF));
		prg_end_addr  = prg_load_addr + 16'(PRG_LEN);
		for (int i = 0; i < PRG_LEN; i++)
			prg_bytes[i] = 8'($random(seed));
		for (int i = 0; i < TAPE_LEN; i++)
			tape_bytes[i] = 8'($random(seed));

		do_reset(1'b1);

		// PRG data and pointer patch
		load_prg();
		for (int i = 0; i < PRG_LEN; i++)
			check_val("prg_data", 16'(prg_bytes[i]), 16'(ram[prg_load_addr + 16'(i)]));
		for (int i = 0; i < 8; i++)
			check_val("prg_ptr", 16'(i[0] ? prg_end_addr[15:8] : prg_end_addr[7:0]),
				16'(ram[c16_map_pkg::PTR_ADDR[i]]));

		// CPU write and read of main RAM
		cpu_ram_access("ram_we_wr", 16'h3A5C, 8'hC3, 1'b0);
		cpu_ram_access("ram_we_rd", 16'h3A5D, 8'h3C, 1'b1);

		// Plus/4 banking over all config values
		for (int cfg = 0; cfg < 16; cfg++) begin
			@(posedge clk_sys);
			kernal_std_i <= cfg[0];
			write_cfg(16'hFDD0 | 16'(cfg));
			check_rom("bank_cs0", 1'b0, 1'b1, 16'h8000, 4'(cfg), 1'b0, 1'b0);
			check_rom("bank_cs1", 1'b1, 1'b0, 16'hC000, 4'(cfg), 1'b0, 1'b0);
			check_rom("bank_fc", 1'b1, 1'b0, 16'hFC40, 4'(cfg), 1'b0, 1'b0);
		end

		// C16 has no config register
		do_reset(1'b0);
		for (int cfg = 1; cfg < 16; cfg += 5) begin
			write_cfg(16'hFDD0 | 16'(cfg));
			check_rom("c16_cs0", 1'b0, 1'b1, 16'h8000, 4'd0, 1'b0, 1'b0);
			check_rom("c16_cs1", 1'b1, 1'b0, 16'hC000, 4'd0, 1'b0, 1'b0);
		end

		// Cartridge halves
		do_reset(1'b1);
		write_cfg(16'hFDD5);
		check_rom("cart_none_lo", 1'b0, 1'b1, 16'h8000, 4'h5, 1'b0, 1'b0);
		check_rom("cart_none_hi", 1'b1, 1'b0, 16'hC000, 4'h5, 1'b0, 1'b0);
		load_cart(25'h0000010);
		check_rom("cart_lo", 1'b0, 1'b1, 16'h8000, 4'h5, 1'b1, 1'b0);
		check_rom("cart_lo_hi", 1'b1, 1'b0, 16'hC000, 4'h5, 1'b1, 1'b0);
		load_cart(25'h0004010);
		check_rom("cart_hi", 1'b1, 1'b0, 16'hC000, 4'h5, 1'b1, 1'b1);

		// Tape playback reads one spare byte past the image
		for (int i = 0; i < TAPE_LEN - 1 + c16_load_pkg::TAPE_TAIL; i++)
			exp_q.push_back(i < TAPE_LEN ? tape_bytes[i] : fill_byte(i));
		@(posedge clk_sys);
		full_rand_en <= 1'b1;
		load_tape();
		@(posedge clk_sys);
		cpu_addr_i <= 16'hFD10;
		cs_io_n_i  <= 1'b0;
		@(negedge clk_sys);
		check_val("tape_play", 16'd1, 16'(tape_play_o));
		check_val("tape_sense", 16'd0, 16'(tape_sense_o));
		@(posedge clk_sys);
		cs_io_n_i <= 1'b1;
		while (exp_q.size() != 0)
			@(negedge clk_sys);
		@(posedge clk_sys);
		full_rand_en <= 1'b0;
		repeat (20) @(posedge clk_sys);
		fifo_empty_i <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_val("tape_stop", 16'd0, 16'(tape_play_o));

		$display("test passed");
		$finish;
	end

endmodule

/* c16_sys_ctrl_sva.sv */
module c16_sys_ctrl_sva (
	input logic clk_sys,
	input logic reset,
	input logic ram_wr_i,
	input logic ram_we_i,
	input logic mem_we_i,
	input logic mem_rd_i,
	input logic fifo_wr_i,
	input logic fifo_full_i,
	input logic ioctl_wait_i
);

	////////////////////////////////////////////////////////////
	// Strobe width
	////////////////////////////////////////////////////////////

	ram_wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		ram_wr_i |=> !ram_wr_i)
		else $error("ram_wr_o held high for more than one cycle");

	mem_rd_single: assert property (@(posedge clk_sys) disable iff (reset)
		mem_rd_i |=> !mem_rd_i)
		else $error("mem_rd_o held high for more than one cycle");

	fifo_wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		fifo_wr_i |=> !fifo_wr_i)
		else $error("fifo_wr_o held high for more than one cycle");

	// A fetch only starts when the FIFO had room
	rd_not_full: assert property (@(posedge clk_sys) disable iff (reset)
		mem_rd_i |-> !$past(fifo_full_i))
		else $error("mem_rd_o issued while fifo_full_i was high");

	strobes_in_reset: assert property (@(posedge clk_sys)
		reset |=> !(ram_wr_i || ram_we_i || mem_we_i || mem_rd_i || fifo_wr_i || ioctl_wait_i))
		else $error("strobe or wait active right after a reset cycle");

endmodule

bind c16_sys_ctrl c16_sys_ctrl_sva c16_sys_ctrl_sva_i (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.ram_wr_i     (ram_wr_o),
	.ram_we_i     (ram_we_o),
	.mem_we_i     (mem_we_o),
	.mem_rd_i     (mem_rd_o),
	.fifo_wr_i    (fifo_wr_o),
	.fifo_full_i  (fifo_full_i),
	.ioctl_wait_i (ioctl_wait_o)
);

/* c16_sys_ctrl.sv */
module c16_sys_ctrl #(
	parameter int TAPE_ADDR_W = 25
) (
	input  logic                                 clk_sys,
	input  logic                                 reset,

	// Download port
	input  logic                                 ioctl_download_i,
	input  logic [7:0]                           ioctl_index_i,
	input  logic                                 ioctl_wr_i,
	input  logic [c16_load_pkg::DL_ADDR_W-1:0]   ioctl_addr_i,
	input  logic [c16_map_pkg::DATA_W-1:0]       ioctl_dout_i,
	output logic                                 ioctl_wait_o,

	// CPU bus
	input  logic [c16_map_pkg::CPU_ADDR_W-1:0]   cpu_addr_i,
	input  logic [c16_map_pkg::DATA_W-1:0]       cpu_dout_i,
	input  logic                                 cpu_rnw_i,
	input  logic                                 cs_ram_n_i,
	input  logic                                 cs0_n_i,
	input  logic                                 cs1_n_i,
	input  logic                                 cs_io_n_i,
	input  logic                                 model_plus4_i,
	input  logic                                 kernal_std_i,
	output c16_map_pkg::rom_src_e                rom_sel_o,
	output logic                                 tape_sense_o,

	// Main RAM
	output logic [c16_map_pkg::CPU_ADDR_W-1:0]   ram_addr_o,
	output logic [c16_map_pkg::DATA_W-1:0]       ram_data_o,
	output logic                                 ram_wr_o,
	output logic                                 ram_we_o,
	output logic [c16_map_pkg::CPU_ADDR_W-1:0]   ram_cpu_addr_o,
	output logic [c16_map_pkg::DATA_W-1:0]       ram_cpu_data_o,

	// Tape memory
	output logic [TAPE_ADDR_W-1:0]               mem_addr_o,
	output logic [c16_map_pkg::DATA_W-1:0]       mem_din_o,
	output logic                                 mem_we_o,
	output logic                                 mem_rd_o,
	input  logic [c16_map_pkg::DATA_W-1:0]       mem_dout_i,
	input  logic                                 mem_ready_i,

	// Cassette FIFO and tape controls
	input  logic                                 fifo_full_i,
	input  logic                                 fifo_empty_i,
	output logic                                 fifo_wr_o,
	output logic [c16_map_pkg::DATA_W-1:0]       fifo_data_o,
	input  logic                                 tape_play_btn_i,
	input  logic                                 tape_unload_i,
	output logic                                 tape_play_o
);

	// CPU side of the RAM port rides with ram_we_o
	assign ram_cpu_addr_o = cpu_addr_i;
	assign ram_cpu_data_o = cpu_dout_i;

	prg_loader prg_loader_i (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.ram_addr_o       (ram_addr_o),
		.ram_data_o       (ram_data_o),
		.ram_wr_o         (ram_wr_o)
	);

	c16_bus_decode c16_bus_decode_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.model_plus4_i (model_plus4_i),
		.kernal_std_i  (kernal_std_i),
		.cpu_addr_i    (cpu_addr_i),
		.cpu_rnw_i     (cpu_rnw_i),
		.cs_ram_n_i    (cs_ram_n_i),
		.cs0_n_i       (cs0_n_i),
		.cs1_n_i       (cs1_n_i),
		.cs_io_n_i     (cs_io_n_i),
		.ioctl_wr_i    (ioctl_wr_i),
		.ioctl_index_i (ioctl_index_i),
		.ioctl_addr_i  (ioctl_addr_i),
		.tape_play_i   (tape_play_o),
		.rom_sel_o     (rom_sel_o),
		.ram_we_o      (ram_we_o),
		.tape_sense_o  (tape_sense_o)
	);

	tape_player #(
		.TAPE_ADDR_W (TAPE_ADDR_W)
	) tape_player_i (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.mem_dout_i       (mem_dout_i),
		.mem_ready_i      (mem_ready_i),
		.fifo_full_i      (fifo_full_i),
		.fifo_empty_i     (fifo_empty_i),
		.tape_play_btn_i  (tape_play_btn_i),
		.tape_unload_i    (tape_unload_i),
		.ioctl_wait_o     (ioctl_wait_o),
		.mem_addr_o       (mem_addr_o),
		.mem_din_o        (mem_din_o),
		.mem_we_o         (mem_we_o),
		.mem_rd_o         (mem_rd_o),
		.fifo_wr_o        (fifo_wr_o),
		.fifo_data_o      (fifo_data_o),
		.tape_play_o      (tape_play_o)
	);

endmodule

/* tape_player.sv */
module tape_player #(
	parameter int TAPE_ADDR_W = 25
) (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 ioctl_download_i,
	input  logic [7:0]                           ioctl_index_i,
	input  logic                                 ioctl_wr_i,
	input  logic [c16_load_pkg::DL_ADDR_W-1:0]   ioctl_addr_i,
	input  logic [c16_map_pkg::DATA_W-1:0]       ioctl_dout_i,
	input  logic [c16_map_pkg::DATA_W-1:0]       mem_dout_i,
	input  logic                                 mem_ready_i,
	input  logic                                 fifo_full_i,
	input  logic                                 fifo_empty_i,
	input  logic                                 tape_play_btn_i,
	input  logic                                 tape_unload_i,
	output logic                                 ioctl_wait_o,
	output logic [TAPE_ADDR_W-1:0]               mem_addr_o,
	output logic [c16_map_pkg::DATA_W-1:0]       mem_din_o,
	output logic                                 mem_we_o,
	output logic                                 mem_rd_o,
	output logic                                 fifo_wr_o,
	output logic [c16_map_pkg::DATA_W-1:0]       fifo_data_o,
	output logic                                 tape_play_o
);

	logic                      tape_load;
	logic                      load_active;
	logic                      tape_clear;
	logic                      tape_loaded;
	logic                      fetch_done;
	logic                      btn_q;
	logic                      empty_q;
	logic [TAPE_ADDR_W-1:0]    wr_addr;
	logic [TAPE_ADDR_W-1:0]    play_addr;
	logic [TAPE_ADDR_W-1:0]    last_addr;
	c16_load_pkg::tape_fetch_e fetch_state;

	assign tape_load   = (ioctl_index_i == c16_load_pkg::DL_TAPE);
	assign load_active = ioctl_download_i && tape_load;
	assign tape_clear  = reset || tape_unload_i || load_active;
	assign tape_loaded = (play_addr < last_addr);
	assign fetch_done  = (fetch_state == c16_load_pkg::FETCH_WAIT) && !mem_rd_o && mem_ready_i;

	// Writes and reads never overlap
	assign mem_addr_o = mem_we_o ? wr_addr : play_addr;

	////////////////////////////////////////////////////////////
	// Download into tape memory
	////////////////////////////////////////////////////////////

	// Hold off the source until the memory takes the byte
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_we_o     <= 1'b0;
			ioctl_wait_o <= 1'b0;
		end else begin
			mem_we_o <= 1'b0;
			if (ioctl_wr_i && tape_load) begin
				mem_we_o     <= 1'b1;
				ioctl_wait_o <= 1'b1;
			end else if (!mem_we_o && ioctl_wait_o && mem_ready_i) begin
				ioctl_wait_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ioctl_wr_i && tape_load) begin
			wr_addr   <= ioctl_addr_i[TAPE_ADDR_W-1:0];
			mem_din_o <= ioctl_dout_i;
		end
	end

	////////////////////////////////////////////////////////////
	// Play control and FIFO fetch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			btn_q   <= 1'b0;
			empty_q <= 1'b0;
		end else begin
			btn_q   <= tape_play_btn_i;
			empty_q <= fifo_empty_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (tape_clear) begin
			play_addr   <= '0;
			last_addr   <= '0;
			tape_play_o <= 1'b0;
			mem_rd_o    <= 1'b0;
			fifo_wr_o   <= 1'b0;
			fetch_state <= c16_load_pkg::FETCH_IDLE;
			// Track the image end, play is armed for when it completes
			if (!reset && !tape_unload_i) begin
				last_addr   <= ioctl_addr_i[TAPE_ADDR_W-1:0] +
					TAPE_ADDR_W'(c16_load_pkg::TAPE_TAIL);
				tape_play_o <= 1'b1;
			end
		end else begin
			if (tape_play_btn_i && !btn_q)
				tape_play_o <= !tape_play_o;
			if (fifo_empty_i && !empty_q)
				tape_play_o <= 1'b0;

			mem_rd_o  <= 1'b0;
			fifo_wr_o <= 1'b0;

			// Let full and ready settle after each strobe
			if (!mem_rd_o && !fifo_wr_o) begin
				case (fetch_state)
					c16_load_pkg::FETCH_IDLE: begin
						if (!fifo_full_i && tape_loaded && !ioctl_wait_o && !mem_we_o) begin
							mem_rd_o    <= 1'b1;
							fetch_state <= c16_load_pkg::FETCH_WAIT;
						end
					end
					c16_load_pkg::FETCH_WAIT: begin
						if (mem_ready_i) begin
							play_addr   <= play_addr + 1'b1;
							fifo_wr_o   <= 1'b1;
							fetch_state <= c16_load_pkg::FETCH_IDLE;
						end
					end
					default: fetch_state <= c16_load_pkg::FETCH_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (fetch_done)
			fifo_data_o <= mem_dout_i;
	end

endmodule

/* c16_bus_decode.sv */
module c16_bus_decode (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 model_plus4_i,
	input  logic                                 kernal_std_i,
	input  logic [c16_map_pkg::CPU_ADDR_W-1:0]   cpu_addr_i,
	input  logic                                 cpu_rnw_i,
	input  logic                                 cs_ram_n_i,
	input  logic                                 cs0_n_i,
	input  logic                                 cs1_n_i,
	input  logic                                 cs_io_n_i,
	input  logic                                 ioctl_wr_i,
	input  logic [7:0]                           ioctl_index_i,
	input  logic [c16_load_pkg::DL_ADDR_W-1:0]   ioctl_addr_i,
	input  logic                                 tape_play_i,
	output c16_map_pkg::rom_src_e                rom_sel_o,
	output logic                                 ram_we_o,
	output logic                                 tape_sense_o
);

	logic        model_q;
	logic        cart_lo_q;
	logic        cart_hi_q;
	logic [1:0]  roml_q;
	logic [1:0]  romh_q;
	logic        io_n_q;
	logic        ram_n_q;
	logic        cart_wr;
	logic [10:0] cart_bank;
	logic        kern_page;

	assign cart_wr   = ioctl_wr_i && (ioctl_index_i == c16_load_pkg::DL_CART);
	assign cart_bank = ioctl_addr_i[c16_load_pkg::DL_ADDR_W-1:14];
	assign kern_page = (cpu_addr_i[15:8] == c16_map_pkg::KERNAL_PAGE);

	// Model only changes across a reset
	always_ff @(posedge clk_sys) begin
		if (reset)
			model_q <= model_plus4_i;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_lo_q <= 1'b0;
			cart_hi_q <= 1'b0;
		end else if (cart_wr) begin
			if (cart_bank == c16_load_pkg::CART_BANK_LO)
				cart_lo_q <= 1'b1;
			if (cart_bank == c16_load_pkg::CART_BANK_HI)
				cart_hi_q <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Config register and RAM write, on select release
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_n_q   <= 1'b1;
			ram_n_q  <= 1'b1;
			roml_q   <= 2'd0;
			romh_q   <= 2'd0;
			ram_we_o <= 1'b0;
		end else begin
			io_n_q   <= cs_io_n_i;
			ram_n_q  <= cs_ram_n_i;
			ram_we_o <= !ram_n_q && cs_ram_n_i && !cpu_rnw_i;

			// Plus/4 only; data is ignored, the low nibble of the address is the value
			if (model_q && !io_n_q && cs_io_n_i && !cpu_rnw_i &&
					cpu_addr_i[15:4] == c16_map_pkg::ROMCFG_WINDOW)
				{romh_q, roml_q} <= cpu_addr_i[3:0];
		end
	end

	////////////////////////////////////////////////////////////
	// ROM selection
	////////////////////////////////////////////////////////////

	always_comb begin
		rom_sel_o = c16_map_pkg::ROM_NONE;
		if (!cs0_n_i) begin
			case (roml_q)
				2'd0: rom_sel_o = c16_map_pkg::ROM_BASIC;
				2'd1: rom_sel_o = cart_lo_q ? c16_map_pkg::ROM_CART_LO : c16_map_pkg::ROM_NONE;
				2'd2: rom_sel_o = c16_map_pkg::ROM_FUNC_LO;
				default: rom_sel_o = c16_map_pkg::ROM_NONE;
			endcase
		end else if (!cs1_n_i) begin
			if (kern_page || romh_q == 2'd0) begin
				rom_sel_o = kernal_std_i ? c16_map_pkg::ROM_KERNAL_STD : c16_map_pkg::ROM_KERNAL;
			end else begin
				case (romh_q)
					2'd1: rom_sel_o = cart_hi_q ? c16_map_pkg::ROM_CART_HI : c16_map_pkg::ROM_NONE;
					2'd2: rom_sel_o = c16_map_pkg::ROM_FUNC_HI;
					default: rom_sel_o = c16_map_pkg::ROM_NONE;
				endcase
			end
		end
	end

	// Sense is active low, pulled down while the tape plays
	assign tape_sense_o = cs_io_n_i ||
		(cpu_addr_i[8:4] != c16_map_pkg::TAPE_IO_WINDOW) || !tape_play_i;

endmodule

/* prg_loader.sv */
module prg_loader (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 ioctl_download_i,
	input  logic [7:0]                           ioctl_index_i,
	input  logic                                 ioctl_wr_i,
	input  logic [c16_load_pkg::DL_ADDR_W-1:0]   ioctl_addr_i,
	input  logic [c16_map_pkg::DATA_W-1:0]       ioctl_dout_i,
	output logic [c16_map_pkg::CPU_ADDR_W-1:0]   ram_addr_o,
	output logic [c16_map_pkg::DATA_W-1:0]       ram_data_o,
	output logic                                 ram_wr_o
);

	logic                               prg_sel;
	logic                               prg_wr;
	logic                               download_q;
	logic [3:0]                         patch_cnt;
	logic [c16_map_pkg::CPU_ADDR_W-1:0] load_addr;

	assign prg_sel = (ioctl_index_i == c16_load_pkg::DL_PRG);
	assign prg_wr  = ioctl_download_i && prg_sel && ioctl_wr_i;

	////////////////////////////////////////////////////////////
	// Write strobe and patch sequencing
	////////////////////////////////////////////////////////////

	// Patch runs from 1 through 15, odd steps write one pointer byte
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
			patch_cnt  <= 4'd0;
			ram_wr_o   <= 1'b0;
		end else begin
			download_q <= ioctl_download_i;
			ram_wr_o   <= 1'b0;

			if (patch_cnt != 4'd0)
				patch_cnt <= patch_cnt + 4'd1;

			if (ioctl_download_i && prg_sel) begin
				patch_cnt <= 4'd0;
				// Header bytes only set the load address
				if (ioctl_wr_i && ioctl_addr_i > 1)
					ram_wr_o <= 1'b1;
			end

			// End of PRG download
			if (download_q && !ioctl_download_i && prg_sel)
				patch_cnt <= 4'd1;

			if (patch_cnt[0])
				ram_wr_o <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Address and data
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (prg_wr) begin
			if (ioctl_addr_i == 0) begin
				load_addr[7:0] <= ioctl_dout_i;
			end else if (ioctl_addr_i == 1) begin
				load_addr[15:8] <= ioctl_dout_i;
			end else begin
				ram_addr_o <= load_addr;
				ram_data_o <= ioctl_dout_i;
				load_addr  <= load_addr + 1'b1;
			end
		end else if (patch_cnt[0]) begin
			// load_addr now points one past the last byte
			ram_addr_o <= c16_map_pkg::PTR_ADDR[patch_cnt[3:1]];
			ram_data_o <= patch_cnt[1] ? load_addr[15:8] : load_addr[7:0];
		end
	end

endmodule

/* c16_load_pkg.sv */
package c16_load_pkg;

	////////////////////////////////////////////////////////////
	// Download port
	////////////////////////////////////////////////////////////

	localparam int DL_ADDR_W = 25;

	// Image type on the download port
	typedef enum logic [7:0] {
		DL_ROM  = 8'd0,
		DL_PRG  = 8'd1,
		DL_CART = 8'd2,
		DL_TAPE = 8'd4
	} dl_index_e;

	// 16K bank number, download address bits 24..14
	localparam logic [10:0] CART_BANK_LO = 11'd0;
	localparam logic [10:0] CART_BANK_HI = 11'd1;

	////////////////////////////////////////////////////////////
	// Tape
	////////////////////////////////////////////////////////////

	typedef enum logic {
		FETCH_IDLE,
		FETCH_WAIT
	} tape_fetch_e;

	// Cassette FIFO checks early, so one spare byte past the end
	localparam int TAPE_TAIL = 2;

endpackage

/* c16_map_pkg.sv */
package c16_map_pkg;

	////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////

	localparam int CPU_ADDR_W = 16;
	localparam int DATA_W     = 8;

	////////////////////////////////////////////////////////////
	// Memory map
	////////////////////////////////////////////////////////////

	// FDD0..FDDF, ROM config register written by address
	localparam logic [11:0] ROMCFG_WINDOW = 12'hFDD;

	// Kernal page, visible whatever romh says
	localparam logic [7:0] KERNAL_PAGE = 8'hFC;

	// Cassette port in the TED I/O area, address bits 8..4
	localparam logic [4:0] TAPE_IO_WINDOW = 5'h11;

	// BASIC start/end pointers, low byte first in each pair
	localparam logic [CPU_ADDR_W-1:0] PTR_ADDR [8] = '{
		16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h009D, 16'h009E
	};

	// ROM source seen by the CPU for the current access
	typedef enum logic [2:0] {
		ROM_NONE,
		ROM_BASIC,
		ROM_KERNAL,
		ROM_KERNAL_STD,
		ROM_FUNC_LO,
		ROM_FUNC_HI,
		ROM_CART_LO,
		ROM_CART_HI
	} rom_src_e;

endpackage
